//--- rtl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  localparam int addr_w   = 16;
  localparam int tag_w    = 5;
  localparam int index_w  = 8;
  localparam int word_w   = 2;
  localparam int offset_w = word_w + 1;  // word plus byte select
  localparam int block_w  = tag_w + index_w;

  typedef logic [tag_w-1:0]    tag_t;
  typedef logic [index_w-1:0]  index_t;
  typedef logic [word_w-1:0]   word_t;
  typedef logic [offset_w-1:0] offset_t;
  typedef logic [addr_w-1:0]   byte_addr_t;

  // how the cache sees an address
  typedef struct packed {
    tag_t   tag;
    index_t index;
    word_t  word;
    logic   byte_sel;
  } cache_view_t;

  // how memory sees it, block number first
  typedef struct packed {
    logic [block_w-1:0] block;
    word_t              word;
    logic               byte_sel;
  } block_view_t;

  typedef union packed {
    byte_addr_t  raw;
    cache_view_t cache_view;
    block_view_t block_view;
  } mem_addr_u;

endpackage

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  localparam int words_per_block = 4;

  // ----------------------------------------
  // controller states
  // ----------------------------------------
  typedef enum logic [4:0] {
    st_idle         = 5'd0,
    st_comp_read    = 5'd1,
    st_comp_write   = 5'd2,
    st_victim_probe = 5'd3,   // write miss, look at the victim line
    st_writeback    = 5'd4,
    st_wb_stall     = 5'd5,
    st_refill       = 5'd6,
    st_refill_tail  = 5'd7,
    st_cache_write  = 5'd8,
    st_done         = 5'd9,
    st_done_hit     = 5'd10
  } state_t;

  typedef enum logic {
    burst_writeback = 1'b0,
    burst_refill    = 1'b1
  } burst_mode_t;

endpackage

`default_nettype wire

//--- rtl/miss_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module miss_fsm (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  read,
  input  logic                  write,
  input  logic                  hit,
  input  logic                  dirty,
  input  logic                  valid,
  input  logic                  burst_last,
  input  logic [3:0]            busy,
  output ctrl_pkg::state_t      state,
  output logic                  burst_start,
  output ctrl_pkg::burst_mode_t burst_kind
);

  import ctrl_pkg::*;

  state_t next_state;
  state_t miss_target;
  logic   req_write;   // request type, held until done

  // one rule for every miss: dirty victim goes out first
  assign miss_target = (dirty && valid) ? st_writeback : st_refill;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (write) begin
          next_state = st_comp_write;  // write wins over read
        end else if (read) begin
          next_state = st_comp_read;
        end
      end
      st_comp_read: begin
        next_state = (hit && valid) ? st_done_hit : miss_target;
      end
      st_comp_write: begin
        next_state = (hit && valid) ? st_done_hit : st_victim_probe;
      end
      st_victim_probe: next_state = miss_target;
      st_writeback: begin
        if (burst_last) begin
          next_state = st_wb_stall;
        end
      end
      st_wb_stall: begin
        if (busy == 4'b0000) begin
          next_state = st_refill;
        end
      end
      st_refill: begin
        if (burst_last) begin
          next_state = req_write ? st_cache_write : st_refill_tail;
        end
      end
      st_refill_tail: next_state = st_done;
      st_cache_write: next_state = st_done;
      st_done:        next_state = st_idle;
      st_done_hit:    next_state = st_idle;
      default:        next_state = st_idle;
    endcase
  end

  // kick the sequencer in the cycle that decides to enter a burst
  assign burst_start = ((next_state == st_writeback) || (next_state == st_refill)) &&
                       (next_state != state);
  assign burst_kind  = (next_state == st_writeback) ? burst_writeback : burst_refill;

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_write <= 1'b0;
    end else if (state == st_idle) begin
      req_write <= write;  // frozen once the compare starts
    end
  end

  // the sequencer only ends a burst that the FSM is waiting on
  a_last_in_burst: assert property (
    @(posedge clk) disable iff (reset)
    burst_last |-> (state inside {st_writeback, st_refill})
  );

endmodule

`default_nettype wire

//--- rtl/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer #(
  parameter int mem_latency = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  burst_start,
  input  ctrl_pkg::burst_mode_t burst_kind,
  output logic                  issue_active,
  output cache_geom_pkg::word_t issue_word,
  output logic                  fill_active,
  output cache_geom_pkg::word_t fill_word,
  output logic                  burst_last
);

  import cache_geom_pkg::*;
  import ctrl_pkg::*;

  localparam word_t last_word = word_t'(words_per_block - 1);

  logic                   issuing;
  word_t                  word_cnt;
  burst_mode_t            mode;
  logic [mem_latency-1:0] pipe_valid;   // reads still waiting on memory data
  word_t                  pipe_word [mem_latency];

  // ----------------------------------------
  // issue counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      issuing  <= 1'b0;
      word_cnt <= '0;
      mode     <= burst_writeback;
    end else if (burst_start) begin
      issuing  <= 1'b1;
      word_cnt <= '0;
      mode     <= burst_kind;
    end else if (issuing) begin
      word_cnt <= word_cnt + 1'b1;
      if (word_cnt == last_word) begin
        issuing <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // fill pipeline, refill only
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid[0] <= issuing && (mode == burst_refill);
      for (int i = 1; i < mem_latency; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_word[0] <= word_cnt;
    for (int i = 1; i < mem_latency; i++) begin
      pipe_word[i] <= pipe_word[i-1];
    end
  end

  assign issue_active = issuing;
  assign issue_word   = word_cnt;
  assign fill_active  = pipe_valid[mem_latency-1];
  assign fill_word    = pipe_word[mem_latency-1];

  // write-back ends on its last issue, refill on its last fill
  assign burst_last = (mode == burst_writeback) ?
                      (issuing && (word_cnt == last_word)) :
                      (fill_active && (fill_word == last_word));

  a_no_overlap: assert property (
    @(posedge clk) disable iff (reset)
    burst_start |-> !(issuing || (|pipe_valid))
  );

endmodule

`default_nettype wire

//--- rtl/cache_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module cache_port_mux (
  input  ctrl_pkg::state_t          state,
  input  logic                      issue_active,
  input  cache_geom_pkg::word_t     issue_word,
  input  logic                      fill_active,
  input  cache_geom_pkg::word_t     fill_word,
  input  cache_geom_pkg::byte_addr_t addr,
  input  cache_geom_pkg::tag_t      cache_tag_in,
  output logic                      enable,
  output logic                      mem_wr,
  output logic                      mem_rd,
  output logic                      comp,
  output logic                      c_write,
  output logic                      valid_in,
  output logic                      mem_cache_wr,
  output logic                      done,
  output logic                      stall_cache,
  output logic                      miss,
  output cache_geom_pkg::byte_addr_t mem_address,
  output cache_geom_pkg::offset_t   cache_offset,
  output cache_geom_pkg::tag_t      cache_tag_out
);

  import cache_geom_pkg::*;
  import ctrl_pkg::*;

  mem_addr_u req;
  mem_addr_u rd_addr;   // request block, word from the burst
  mem_addr_u wb_addr;   // victim block
  offset_t   req_offset;

  assign req        = addr;
  assign req_offset = {req.cache_view.word, req.cache_view.byte_sel};

  always_comb begin
    rd_addr                  = req;
    rd_addr.block_view.word  = issue_word;
    wb_addr                  = rd_addr;
    wb_addr.block_view.block = {cache_tag_in, req.cache_view.index};
  end

  // ----------------------------------------
  // strobes and addresses per state
  // ----------------------------------------
  always_comb begin
    enable        = 1'b1;
    stall_cache   = 1'b1;
    mem_wr        = 1'b0;
    mem_rd        = 1'b0;
    comp          = 1'b0;
    c_write       = 1'b0;
    valid_in      = 1'b0;
    mem_cache_wr  = 1'b0;
    done          = 1'b0;
    miss          = 1'b1;   // every state past compare is a miss, bar done_hit
    cache_offset  = req_offset;
    cache_tag_out = req.cache_view.tag;
    mem_address   = req.raw;
    case (state)
      st_idle: begin
        enable        = 1'b0;
        stall_cache   = 1'b0;
        miss          = 1'b0;
        cache_offset  = '0;
        cache_tag_out = '0;
        mem_address   = '0;
      end
      st_comp_read: begin
        comp = 1'b1;
        miss = 1'b0;
      end
      st_comp_write: begin
        comp    = 1'b1;
        c_write = 1'b1;
        miss    = 1'b0;
      end
      st_writeback: begin
        mem_wr       = issue_active;
        cache_offset = {issue_word, req.cache_view.byte_sel};  // victim word out of the cache
        mem_address  = wb_addr.raw;
      end
      st_refill: begin
        mem_rd       = issue_active;
        c_write      = fill_active;
        valid_in     = fill_active;
        mem_cache_wr = fill_active;
        if (issue_active) begin
          mem_address = rd_addr.raw;
        end
        if (fill_active) begin
          cache_offset = {fill_word, req.cache_view.byte_sel};
        end
      end
      st_cache_write: begin
        comp     = 1'b1;
        c_write  = 1'b1;
        valid_in = 1'b1;
      end
      st_done:     done = 1'b1;
      st_done_hit: begin
        done = 1'b1;
        miss = 1'b0;
      end
      default: ;    // probe, stall and tail keep the defaults
    endcase
  end

  // sequencer activity only lines up with a burst state
  a_burst_in_state: assert final (
    ((issue_active !== 1'b1) || (state inside {st_writeback, st_refill})) &&
    ((fill_active !== 1'b1) || (state == st_refill))
  );

endmodule

`default_nettype wire

//--- rtl/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
  parameter int mem_latency = 2   // cycles from mem_rd to data
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       read,
  input  logic                       write,
  input  logic                       hit,
  input  logic                       dirty,
  input  logic                       valid,
  input  cache_geom_pkg::byte_addr_t addr,
  input  logic [3:0]                 busy,
  input  cache_geom_pkg::tag_t       cache_tag_in,
  output logic                       enable,
  output logic                       mem_wr,
  output logic                       mem_rd,
  output logic                       comp,
  output logic                       c_write,
  output logic                       valid_in,
  output logic                       mem_cache_wr,
  output logic                       done,
  output logic                       stall_cache,
  output logic                       miss,
  output cache_geom_pkg::byte_addr_t mem_address,
  output cache_geom_pkg::offset_t    cache_offset,
  output cache_geom_pkg::tag_t       cache_tag_out
);

  import cache_geom_pkg::*;
  import ctrl_pkg::*;

  state_t      state;
  logic        burst_start;
  burst_mode_t burst_kind;
  logic        burst_last;
  logic        issue_active;
  word_t       issue_word;
  logic        fill_active;
  word_t       fill_word;

  miss_fsm fsm_i (
    .clk         (clk),
    .reset       (reset),
    .read        (read),
    .write       (write),
    .hit         (hit),
    .dirty       (dirty),
    .valid       (valid),
    .burst_last  (burst_last),
    .busy        (busy),
    .state       (state),
    .burst_start (burst_start),
    .burst_kind  (burst_kind)
  );

  burst_sequencer #(
    .mem_latency (mem_latency)
  ) seq_i (
    .clk          (clk),
    .reset        (reset),
    .burst_start  (burst_start),
    .burst_kind   (burst_kind),
    .issue_active (issue_active),
    .issue_word   (issue_word),
    .fill_active  (fill_active),
    .fill_word    (fill_word),
    .burst_last   (burst_last)
  );

  cache_port_mux mux_i (
    .state         (state),
    .issue_active  (issue_active),
    .issue_word    (issue_word),
    .fill_active   (fill_active),
    .fill_word     (fill_word),
    .addr          (addr),
    .cache_tag_in  (cache_tag_in),
    .enable        (enable),
    .mem_wr        (mem_wr),
    .mem_rd        (mem_rd),
    .comp          (comp),
    .c_write       (c_write),
    .valid_in      (valid_in),
    .mem_cache_wr  (mem_cache_wr),
    .done          (done),
    .stall_cache   (stall_cache),
    .miss          (miss),
    .mem_address   (mem_address),
    .cache_offset  (cache_offset),
    .cache_tag_out (cache_tag_out)
  );

endmodule

`default_nettype wire

//--- testbench/tb_checks.svh
`ifndef tb_checks_svh
`define tb_checks_svh

// ----------------------------------------
// reset and rules for every cycle
// ----------------------------------------
a_reset_quiet: assert property (@(posedge clk)
  reset |=> ({enable, mem_wr, mem_rd, comp, c_write, valid_in, mem_cache_wr, done,
              stall_cache, miss} == '0) && (mem_address == '0) && (cache_offset == '0) &&
            (cache_tag_out == '0))
  else begin
    errors++;
    $display("[FAIL] outputs after reset: strobes %h mem_address %h offset %h tag %h",
             $sampled({enable, mem_wr, mem_rd, comp, c_write, valid_in, mem_cache_wr, done,
                       stall_cache, miss}), $sampled(mem_address), $sampled(cache_offset),
             $sampled(cache_tag_out));
  end

a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
  else begin
    errors++;
    $display("done stayed high for more than one cycle");
  end

a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(mem_rd && mem_wr))
  else begin
    errors++;
    $display("mem_rd and mem_wr were high in the same cycle");
  end

a_hit_timing: assert property (@(posedge clk) disable iff (reset)
  (req_fire && hit && valid) |=> (!done && !miss && !mem_rd && !mem_wr)
                                 ##1 (done && !miss && !mem_rd && !mem_wr))
  else begin
    errors++;
    $display("hit did not finish with done two cycles after the request");
  end

// ----------------------------------------
// bursts, fills and stall
// ----------------------------------------
a_rd_burst: assert property (@(posedge clk) disable iff (reset)
  $rose(mem_rd) |-> mem_rd[*4] ##1 !mem_rd)
  else begin
    errors++;
    $display("refill reads were not four consecutive cycles");
  end

a_rd_address: assert property (@(posedge clk) disable iff (reset)
  mem_rd |-> (mem_address == exp_rd_address))
  else begin
    errors++;
    $display("[FAIL] mem_address (read): got %h expected %h",
             $sampled(mem_address), $sampled(exp_rd_address));
  end

a_fill: assert property (@(posedge clk) disable iff (reset)
  fill_due |-> (mem_cache_wr && c_write && valid_in &&
                (cache_offset == {fill_due_word, addr[0]})))
  else begin
    errors++;
    $display("[FAIL] cache_offset (fill): got %h expected %h, strobes %h",
             $sampled(cache_offset), $sampled({fill_due_word, addr[0]}),
             $sampled({mem_cache_wr, c_write, valid_in}));
  end

a_fill_only_due: assert property (@(posedge clk) disable iff (reset) mem_cache_wr |-> fill_due)
  else begin
    errors++;
    $display("mem_cache_wr came without a matching read");
  end

a_miss_held: assert property (@(posedge clk) disable iff (reset)
  (in_txn && miss_txn && (txn_cycle >= 2)) |-> miss)
  else begin
    errors++;
    $display("[FAIL] miss: got %h expected 1", $sampled(miss));
  end

a_wr_burst: assert property (@(posedge clk) disable iff (reset)
  $rose(mem_wr) |-> mem_wr[*4] ##1 !mem_wr)
  else begin
    errors++;
    $display("write-back was not four consecutive cycles");
  end

a_wr_address: assert property (@(posedge clk) disable iff (reset)
  mem_wr |-> (mem_address == exp_wr_address))
  else begin
    errors++;
    $display("[FAIL] mem_address (write-back): got %h expected %h",
             $sampled(mem_address), $sampled(exp_wr_address));
  end

a_stall_quiet: assert property (@(posedge clk) disable iff (reset)
  (in_txn && (wr_count == 3'd4) && (rd_count == 3'd0) && (busy != 4'h0)) |=> (!mem_rd && !mem_wr))
  else begin
    errors++;
    $display("memory strobe while the banks were still busy");
  end

a_refill_after_busy: assert property (@(posedge clk) disable iff (reset)
  ((wr_count == 3'd4) && $rose(mem_rd)) |-> ($past(busy) == 4'h0))
  else begin
    errors++;
    $display("refill started before busy went to zero");
  end

// ----------------------------------------
// final write of a write miss
// ----------------------------------------
a_wr_miss_write: assert property (@(posedge clk) disable iff (reset)
  (done && miss && txn_write) |-> $past(comp && c_write && valid_in && !mem_cache_wr))
  else begin
    errors++;
    $display("write miss reached done without a cache write in the cycle before");
  end

a_wr_miss_fields: assert property (@(posedge clk) disable iff (reset)
  (comp && c_write && valid_in) |-> ((cache_offset == addr[2:0]) &&
                                     (cache_tag_out == addr[15:11])))
  else begin
    errors++;
    $display("[FAIL] cache_offset/cache_tag_out: got %h/%h expected %h/%h",
             $sampled(cache_offset), $sampled(cache_tag_out),
             $sampled(addr[2:0]), $sampled(addr[15:11]));
  end

`endif

//--- testbench/tb_cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_controller;

  import cache_geom_pkg::*;

  localparam int mem_latency = 2;
  localparam int done_limit  = 200;  // cycles allowed for one transaction
  localparam int idle_limit  = 10;

  logic       clk;
  logic       reset;
  logic       read;
  logic       write;
  logic       hit;
  logic       dirty;
  logic       valid;
  byte_addr_t addr;
  logic [3:0] busy;
  tag_t       cache_tag_in;
  logic       enable;
  logic       mem_wr;
  logic       mem_rd;
  logic       comp;
  logic       c_write;
  logic       valid_in;
  logic       mem_cache_wr;
  logic       done;
  logic       stall_cache;
  logic       miss;
  byte_addr_t mem_address;
  offset_t    cache_offset;
  tag_t       cache_tag_out;

  integer seed;
  int     errors;
  int     timeouts;
  int     txn_count;

  // ----------------------------------------
  // transaction tracking
  // ----------------------------------------
  logic                   req_fire;
  logic                   in_txn;
  logic                   miss_txn;
  logic                   txn_write;
  int                     txn_cycle;
  logic [2:0]             rd_count;
  logic [2:0]             wr_count;
  logic [mem_latency-1:0] fill_due_pipe;   // reads whose data is still on its way
  logic [1:0]             fill_word_pipe [mem_latency];
  logic                   fill_due;
  logic [1:0]             fill_due_word;
  byte_addr_t             exp_rd_address;
  byte_addr_t             exp_wr_address;

  cache_controller #(
    .mem_latency (mem_latency)
  ) dut_i (
    .clk           (clk),
    .reset         (reset),
    .read          (read),
    .write         (write),
    .hit           (hit),
    .dirty         (dirty),
    .valid         (valid),
    .addr          (addr),
    .busy          (busy),
    .cache_tag_in  (cache_tag_in),
    .enable        (enable),
    .mem_wr        (mem_wr),
    .mem_rd        (mem_rd),
    .comp          (comp),
    .c_write       (c_write),
    .valid_in      (valid_in),
    .mem_cache_wr  (mem_cache_wr),
    .done          (done),
    .stall_cache   (stall_cache),
    .miss          (miss),
    .mem_address   (mem_address),
    .cache_offset  (cache_offset),
    .cache_tag_out (cache_tag_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign req_fire       = !enable && (read || write);  // enable is low only in idle
  assign fill_due       = fill_due_pipe[mem_latency-1];
  assign fill_due_word  = fill_word_pipe[mem_latency-1];
  assign exp_rd_address = {addr[15:3], rd_count[1:0], addr[0]};
  assign exp_wr_address = {cache_tag_in, addr[10:3], wr_count[1:0], addr[0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      in_txn    <= 1'b0;
      miss_txn  <= 1'b0;
      txn_write <= 1'b0;
      txn_cycle <= 0;
      rd_count  <= '0;
      wr_count  <= '0;
    end else if (req_fire) begin
      in_txn    <= 1'b1;
      miss_txn  <= !(hit && valid);
      txn_write <= write;
      txn_cycle <= 1;
      rd_count  <= '0;
      wr_count  <= '0;
    end else begin
      if (done) begin
        in_txn <= 1'b0;
      end
      txn_cycle <= txn_cycle + 1;
      if (mem_rd) begin
        rd_count <= rd_count + 1'b1;
      end
      if (mem_wr) begin
        wr_count <= wr_count + 1'b1;
      end
    end
  end

  // word k lands in the cache mem_latency cycles after its read
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_due_pipe <= '0;
    end else begin
      fill_due_pipe[0]  <= mem_rd;
      fill_word_pipe[0] <= rd_count[1:0];
      for (int i = 1; i < mem_latency; i++) begin
        fill_due_pipe[i]  <= fill_due_pipe[i-1];
        fill_word_pipe[i] <= fill_word_pipe[i-1];
      end
    end
  end

  `include "tb_checks.svh"

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [3:0] random_busy();
    logic [31:0] r;
    r = $random(seed);
    return (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
  endfunction

  task automatic run_txn(input logic is_write, input logic hit_arg,
                         input logic dirty_arg, input logic valid_arg);
    int          n;
    int          stall_left;
    logic [31:0] r;
    r            = $random(seed);
    addr         = r[15:0];
    r            = $random(seed);
    cache_tag_in = r[4:0];
    stall_left   = 2 + int'(r[10:8] % 5);
    hit          = hit_arg;
    dirty        = dirty_arg;
    valid        = valid_arg;
    busy         = random_busy();   // only matters once the write-back is out
    read         = !is_write;
    write        = is_write;
    txn_count++;
    n = 0;
    do begin
      tick();
      n++;
      if ((wr_count == 3'd4) && (busy != 4'h0)) begin
        stall_left--;
        busy = (stall_left > 0) ? random_busy() : 4'h0;
      end
    end while (!done && (n < done_limit));
    if (!done) begin
      $display("timeout: no done within %0d cycles of request %0d", done_limit, txn_count);
      timeouts++;
    end
    read  = 1'b0;
    write = 1'b0;
    busy  = 4'h0;
    n = 0;
    do begin
      tick();
      n++;
    end while (enable && (n < idle_limit));
    if (enable) begin
      $display("timeout: controller did not return to idle after request %0d", txn_count);
      timeouts++;
    end
  endtask

  initial begin
    int kind;
    seed         = 32'hd2a5a335;
    errors       = 0;
    timeouts     = 0;
    txn_count    = 0;
    reset        = 1'b1;
    read         = 1'b0;
    write        = 1'b0;
    hit          = 1'b0;
    dirty        = 1'b0;
    valid        = 1'b0;
    addr         = '0;
    busy         = 4'h0;
    cache_tag_in = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    tick();
    // read hit, write hit, invalid miss, dirty read miss, clean and dirty write miss
    for (int i = 0; i < 18; i++) begin
      kind = i % 6;
      if (timeouts == 0) begin
        run_txn((kind == 1) || (kind >= 4), kind <= 1, (kind == 3) || (kind == 5), kind != 2);
      end
    end
    tick();
    tick();
    $display("errors: %0d  timeouts: %0d  transactions: %0d", errors, timeouts, txn_count);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_ctrl.f
+incdir+testbench
rtl/cache_geom_pkg.sv
rtl/ctrl_pkg.sv
rtl/miss_fsm.sv
rtl/burst_sequencer.sv
rtl/cache_port_mux.sv
rtl/cache_controller.sv
testbench/tb_cache_controller.sv

//--- Bender.yml
package:
  name: cache_ctrl

sources:
  - rtl/cache_geom_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/miss_fsm.sv
  - rtl/burst_sequencer.sv
  - rtl/cache_port_mux.sv
  - rtl/cache_controller.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_cache_controller.sv
